/* list.f */
hw/xbar_cfg_pkg.sv
hw/xbar_types_pkg.sv
hw/xbar_addr_decode.sv
hw/xbar_arbiter.sv
hw/xbar_req_mux.sv
hw/xbar_resp_route.sv
hw/tcdm_xbar.sv
verif/tb_bank_model.sv
verif/tcdm_xbar_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tcdm_xbar_tb -o sim_tcdm_xbar
./obj_dir/sim_tcdm_xbar > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    exit 1
fi

/* verif/tcdm_xbar_tb.sv */
`timescale 1ns/1ps

module tcdm_xbar_tb
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
();

    localparam int N_REQ = 60;                         // Requests per master
    localparam int LIMIT = 4 * N_MASTER * N_REQ + 200; // Timeout in cycles

    logic                    clk;
    logic                    rst_n_i;

    // Master side
    logic [N_MASTER-1:0]     data_req_i;
    addr_t [N_MASTER-1:0]    data_add_i;
    logic [N_MASTER-1:0]     data_wen_i;      // 1 load, 0 store
    data_t [N_MASTER-1:0]    data_wdata_i;
    be_t [N_MASTER-1:0]      data_be_i;
    logic [N_MASTER-1:0]     data_gnt_o;
    logic [N_MASTER-1:0]     data_r_valid_o;
    data_t [N_MASTER-1:0]    data_r_rdata_o;

    // Bank side
    logic [N_BANK-1:0]       data_req_o;
    row_t [N_BANK-1:0]       data_add_o;
    logic [N_BANK-1:0]       data_wen_o;
    data_t [N_BANK-1:0]      data_wdata_o;
    be_t [N_BANK-1:0]        data_be_o;
    master_id_t [N_BANK-1:0] data_id_o;
    logic [N_BANK-1:0]       data_gnt_i;      // Random back-pressure
    logic [N_BANK-1:0]       data_r_valid_i;
    data_t [N_BANK-1:0]      data_r_rdata_i;
    master_id_t [N_BANK-1:0] data_r_id_i;

    int errors = 0;
    int cycles = 0;
    int issued [N_MASTER];      // Granted requests per master
    int others_gnt [N_MASTER];  // Grants to rivals while waiting
    logic [N_MASTER-1:0] prev_gnt;
    logic [N_MASTER-1:0] chk_load;  // Load response due this cycle
    data_t chk_data [N_MASTER];
    data_t chk_mask [N_MASTER];
    data_t shadow [N_BANK][1 << ROW_W];  // Expected memory contents

    tcdm_xbar tcdm_xbar_inst (.*);

    tb_bank_model bank_model_inst
    (
        .clk       ( clk            ),
        .rst_n_i   ( rst_n_i        ),
        .req_i     ( data_req_o     ),
        .add_i     ( data_add_o     ),
        .wen_i     ( data_wen_o     ),
        .wdata_i   ( data_wdata_o   ),
        .be_i      ( data_be_o      ),
        .id_i      ( data_id_o      ),
        .gnt_o     ( data_gnt_i     ),
        .r_valid_o ( data_r_valid_i ),
        .r_rdata_o ( data_r_rdata_i ),
        .r_id_o    ( data_r_id_i    )
    );

    function automatic int bank_of(addr_t a);
        return int'(a[BANK_SEL_LSB +: BANK_SEL_W]);  // Interleave bits
    endfunction

    // Byte enables widened to a bit mask
    function automatic data_t be_mask(be_t be);
        data_t mask = '0;
        for (int i = 0; i < BE_W; i++)
            if (be[i])
                mask[8*i +: 8] = 8'hff;
        return mask;
    endfunction

    ///////////////////////////////
    // Expected bank payload

    int id_m [N_BANK];      // Master named by data_id_o
    int gnt_cnt [N_BANK];   // Master grants landing on each bank

    always_comb
    begin
        for (int b = 0; b < N_BANK; b++)
        begin
            id_m[b]    = 0;
            gnt_cnt[b] = 0;
            for (int m = 0; m < N_MASTER; m++)
            begin
                if (data_id_o[b][m])
                    id_m[b] = m;
                if (data_gnt_o[m] && bank_of(data_add_i[m]) == b)
                    gnt_cnt[b]++;
            end
        end
    end

    ///////////////////////////////
    // Checks

    for (genvar b = 0; b < N_BANK; b++)
    begin : g_bank_chk
        wire              take      = data_req_o[b] && data_gnt_i[b];  // Handed over
        wire              exp_wen   = data_wen_i[id_m[b]];
        wire [BE_W-1:0]   exp_be    = data_be_i[id_m[b]];
        wire [DATA_W-1:0] exp_wdata = data_wdata_i[id_m[b]];
        wire [ROW_W-1:0]  exp_row   = data_add_i[id_m[b]][ROW_LSB +: ROW_W];

        assert property (@(posedge clk) disable iff (!rst_n_i) take |-> $onehot(data_id_o[b]))
        else
        begin
            errors++;
            $display("Error data_id_o[%0d] = %h, not one-hot", b, $sampled(data_id_o[b]));
        end

        // Named master must really target this bank
        assert property (@(posedge clk) disable iff (!rst_n_i)
            take |-> data_req_i[id_m[b]] && bank_of(data_add_i[id_m[b]]) == b)
        else
        begin
            errors++;
            $display("Bank %0d took a request its master did not send", b);
        end

        assert property (@(posedge clk) disable iff (!rst_n_i) take |-> data_add_o[b] == exp_row)
        else
        begin
            errors++;
            $display("Error data_add_o[%0d] = %h, expected %h", b,
                     $sampled(data_add_o[b]), $sampled(exp_row));
        end

        assert property (@(posedge clk) disable iff (!rst_n_i) take |-> data_wen_o[b] == exp_wen)
        else
        begin
            errors++;
            $display("Error data_wen_o[%0d] = %h, expected %h", b,
                     $sampled(data_wen_o[b]), $sampled(exp_wen));
        end

        assert property (@(posedge clk) disable iff (!rst_n_i) take |-> data_be_o[b] == exp_be)
        else
        begin
            errors++;
            $display("Error data_be_o[%0d] = %h, expected %h", b,
                     $sampled(data_be_o[b]), $sampled(exp_be));
        end

        assert property (@(posedge clk) disable iff (!rst_n_i)
            take |-> data_wdata_o[b] == exp_wdata)
        else
        begin
            errors++;
            $display("Error data_wdata_o[%0d] = %h, expected %h", b,
                     $sampled(data_wdata_o[b]), $sampled(exp_wdata));
        end

        // Exactly one master grant per taken request
        assert property (@(posedge clk) disable iff (!rst_n_i) gnt_cnt[b] == (take ? 1 : 0))
        else
        begin
            errors++;
            $display("Bank %0d granted %0d masters", b, $sampled(gnt_cnt[b]));
        end
    end

    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_master_chk
        assert property (@(posedge clk) disable iff (!rst_n_i)
            data_gnt_o[m] |-> data_req_i[m] && data_gnt_i[bank_of(data_add_i[m])])
        else
        begin
            errors++;
            $display("Master %0d granted without request or ready bank", m);
        end

        assert property (@(posedge clk) disable iff (!rst_n_i) others_gnt[m] <= N_MASTER - 1)
        else
        begin
            errors++;
            $display("Master %0d starved by round robin", m);
        end

        // Response exactly one cycle after the grant
        assert property (@(posedge clk) disable iff (!rst_n_i) data_r_valid_o[m] == prev_gnt[m])
        else
        begin
            errors++;
            $display("Error data_r_valid_o[%0d] = %h, expected %h", m,
                     $sampled(data_r_valid_o[m]), $sampled(prev_gnt[m]));
        end

        assert property (@(posedge clk) disable iff (!rst_n_i) data_r_valid_o[m] && chk_load[m]
            |-> (data_r_rdata_o[m] & chk_mask[m]) == chk_data[m])
        else
        begin
            errors++;
            $display("Error data_r_rdata_o[%0d] = %h, expected %h", m,
                     $sampled(data_r_rdata_o[m] & chk_mask[m]), $sampled(chk_data[m]));
        end
    end

    ///////////////////////////////
    // Clock, reset and masters

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Same start pattern as the bank storage
    initial
    begin
        for (int b = 0; b < N_BANK; b++)
            for (int r = 0; r < (1 << ROW_W); r++)
                shadow[b][r] = data_t'(32'h3c5a_0000 ^ (((b << ROW_W) | r) * 32'h0000_9e37));
    end

    always @(posedge clk)
    begin
        prev_gnt <= data_gnt_o & {N_MASTER{rst_n_i}};
        for (int m = 0; m < N_MASTER; m++)
        begin
            chk_load[m] <= 1'b0;
            if (rst_n_i && data_req_i[m] && data_gnt_o[m])
            begin
                issued[m] = issued[m] + 1;
                chk_load[m] <= data_wen_i[m];
                chk_mask[m] <= be_mask(data_be_i[m]);
                chk_data[m] <= shadow[bank_of(data_add_i[m])][data_add_i[m][ROW_LSB +: ROW_W]]
                               & be_mask(data_be_i[m]);  // Word before any store lands
                if (!data_wen_i[m])
                    for (int i = 0; i < BE_W; i++)
                        if (data_be_i[m][i])
                            shadow[bank_of(data_add_i[m])][data_add_i[m][ROW_LSB +: ROW_W]]
                                [8*i +: 8] = data_wdata_i[m][8*i +: 8];
            end
            // Waiting master counts grants its bank gives away
            if (data_req_i[m] && !data_gnt_o[m])
                others_gnt[m] <= others_gnt[m] + gnt_cnt[bank_of(data_add_i[m])];
            else
                others_gnt[m] <= 0;
            // New request only once the old one is gone
            if (rst_n_i && (!data_req_i[m] || data_gnt_o[m]))
            begin
                data_req_i[m] <= issued[m] < N_REQ && ($urandom % 4) != 0;  // Random gaps
                data_wen_i[m] <= ($urandom % 2) != 0;
                data_add_i[m] <= (addr_t'(($urandom % 4) * 341) << ROW_LSB)  // Small row pool
                                 | (addr_t'($urandom % N_BANK) << BANK_SEL_LSB);
                data_wdata_i[m] <= data_t'($urandom);
                data_be_i[m] <= be_t'($urandom % 15 + 1);  // Never an empty mask
            end
        end
    end

    ///////////////////////////////
    // Run control

    initial
    begin
        void'($urandom(32'h053bc576));  // Single seed for the whole run
        rst_n_i = 1'b0;
        data_req_i = '0;
        data_add_i = '0;
        data_wen_i = '0;
        data_wdata_i = '0;
        data_be_i = '0;
        for (int m = 0; m < N_MASTER; m++)
        begin
            issued[m] = 0;
            others_gnt[m] = 0;
        end
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        // Progress is looked at mid cycle when all masters have settled
        while (cycles < LIMIT && !(data_req_i == '0 && issued.sum() == N_MASTER * N_REQ))
        begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= LIMIT)
            $display("Timeout after %0d cycles with %0d requests done", cycles, issued.sum());
        repeat (3) @(posedge clk);  // Let the last responses drain
        $display("Errors: %0d, cycles: %0d", errors, cycles);
        if (errors == 0 && cycles < LIMIT)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verif/tb_bank_model.sv */
`timescale 1ns/1ps

module tb_bank_model
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [N_BANK-1:0]       req_i,      // Request from the crossbar
    input  row_t [N_BANK-1:0]       add_i,      // Row inside each bank
    input  logic [N_BANK-1:0]       wen_i,      // 1 load, 0 store
    input  data_t [N_BANK-1:0]      wdata_i,
    input  be_t [N_BANK-1:0]        be_i,
    input  master_id_t [N_BANK-1:0] id_i,       // Tag to echo back
    output logic [N_BANK-1:0]       gnt_o,      // Random back-pressure
    output logic [N_BANK-1:0]       r_valid_o,  // One cycle after a take
    output data_t [N_BANK-1:0]      r_rdata_o,
    output master_id_t [N_BANK-1:0] r_id_o
);

    data_t mem [N_BANK][1 << ROW_W];  // Bank storage

    // Start pattern, mixes bank and row so every word differs
    function automatic data_t fill_word(int b, int r);
        return data_t'(32'h3c5a_0000 ^ (((b << ROW_W) | r) * 32'h0000_9e37));
    endfunction

    initial
    begin
        for (int b = 0; b < N_BANK; b++)
            for (int r = 0; r < (1 << ROW_W); r++)
                mem[b][r] = fill_word(b, r);
    end

    ///////////////////////////////
    // Grant, storage and response

    always @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            gnt_o     <= '0;
            r_valid_o <= '0;
            r_rdata_o <= '0;
            r_id_o    <= '0;
        end
        else
        begin
            for (int b = 0; b < N_BANK; b++)
            begin
                gnt_o[b]     <= ($urandom % 4) != 0;  // Drop grant one cycle in four
                r_valid_o[b] <= req_i[b] && gnt_o[b];
                r_id_o[b]    <= id_i[b];
                r_rdata_o[b] <= '0;
                if (req_i[b] && gnt_o[b] && wen_i[b])
                    r_rdata_o[b] <= mem[b][add_i[b]];  // Load sees old word
                if (req_i[b] && gnt_o[b] && !wen_i[b])
                    for (int i = 0; i < BE_W; i++)
                        if (be_i[b][i])
                            mem[b][add_i[b]][8*i +: 8] = wdata_i[b][8*i +: 8];
            end
        end
    end

endmodule

/* hw/tcdm_xbar.sv */
`timescale 1ns/1ps

module tcdm_xbar
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n_i,

    // Master side
    input  logic [N_MASTER-1:0]        data_req_i,     // Request per master
    input  addr_t [N_MASTER-1:0]       data_add_i,     // Byte address
    input  logic [N_MASTER-1:0]        data_wen_i,     // 1 load, 0 store
    input  data_t [N_MASTER-1:0]       data_wdata_i,   // Store data
    input  be_t [N_MASTER-1:0]         data_be_i,      // Byte enables
    output logic [N_MASTER-1:0]        data_gnt_o,     // Request transferred
    output logic [N_MASTER-1:0]        data_r_valid_o, // Response strobe
    output data_t [N_MASTER-1:0]       data_r_rdata_o, // Load data

    // Bank side
    output logic [N_BANK-1:0]          data_req_o,
    output row_t [N_BANK-1:0]          data_add_o,     // Row inside the bank
    output logic [N_BANK-1:0]          data_wen_o,
    output data_t [N_BANK-1:0]         data_wdata_o,
    output be_t [N_BANK-1:0]           data_be_o,
    output master_id_t [N_BANK-1:0]    data_id_o,      // One-hot requester tag
    input  logic [N_BANK-1:0]          data_gnt_i,     // Bank ready
    input  logic [N_BANK-1:0]          data_r_valid_i,
    input  data_t [N_BANK-1:0]         data_r_rdata_i,
    input  master_id_t [N_BANK-1:0]    data_r_id_i     // Tag echoed by the bank
);

    //////////////////////////////
    // Internal wires

    row_t [N_MASTER-1:0]             row;       // Decoded row per master
    logic [N_BANK-1:0][N_MASTER-1:0] bank_req;  // Requester matrix
    master_idx_t [N_BANK-1:0]        win_idx;   // Arbitration result

    // Bank select only feeds the request matrix inside the decoder
    xbar_addr_decode i_addr_decode
    (
        .data_req_i     ( data_req_i     ),
        .data_add_i     ( data_add_i     ),
        .bank_sel_o     (                ),
        .row_o          ( row            ),
        .bank_req_o     ( bank_req       )
    );

    xbar_arbiter i_arbiter
    (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .bank_req_i     ( bank_req       ),
        .data_gnt_i     ( data_gnt_i     ),
        .data_req_o     ( data_req_o     ),
        .win_idx_o      ( win_idx        ),
        .data_gnt_o     ( data_gnt_o     )
    );

    xbar_req_mux i_req_mux
    (
        .win_idx_i      ( win_idx        ),
        .row_i          ( row            ),
        .data_wen_i     ( data_wen_i     ),
        .data_wdata_i   ( data_wdata_i   ),
        .data_be_i      ( data_be_i      ),
        .data_add_o     ( data_add_o     ),
        .data_wen_o     ( data_wen_o     ),
        .data_wdata_o   ( data_wdata_o   ),
        .data_be_o      ( data_be_o      ),
        .data_id_o      ( data_id_o      )
    );

    // Response side needs no address, the tag alone finds the master
    xbar_resp_route i_resp_route
    (
        .data_r_valid_i ( data_r_valid_i ),
        .data_r_rdata_i ( data_r_rdata_i ),
        .data_r_id_i    ( data_r_id_i    ),
        .data_r_valid_o ( data_r_valid_o ),
        .data_r_rdata_o ( data_r_rdata_o )
    );

endmodule

/* hw/xbar_resp_route.sv */
`timescale 1ns/1ps

module xbar_resp_route
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic [N_BANK-1:0]       data_r_valid_i,  // Bank response strobe
    input  data_t [N_BANK-1:0]      data_r_rdata_i,  // Bank read data
    input  master_id_t [N_BANK-1:0] data_r_id_i,     // Tag of the original requester
    output logic [N_MASTER-1:0]     data_r_valid_o,  // Response strobe per master
    output data_t [N_MASTER-1:0]    data_r_rdata_o   // Read data per master
);

    //////////////////////////////
    // Tag match

    logic [N_MASTER-1:0][N_BANK-1:0] hit;  // Bank b answers master m

    always_comb
    begin
        for (int m = 0; m < N_MASTER; m++)
        begin
            for (int b = 0; b < N_BANK; b++)
            begin
                hit[m][b] = data_r_valid_i[b] && data_r_id_i[b][m];
            end
        end
    end

    //////////////////////////////
    // And-or data select

    // A master has one grant per cycle, so at most one bank answers it
    always_comb
    begin
        for (int m = 0; m < N_MASTER; m++)
        begin
            data_r_valid_o[m] = |hit[m];
            data_r_rdata_o[m] = '0;           // Zero while nothing comes back
            for (int b = 0; b < N_BANK; b++)
            begin
                if (hit[m][b])
                    data_r_rdata_o[m] = data_r_rdata_o[m] | data_r_rdata_i[b];
            end
        end
    end

endmodule

/* hw/xbar_req_mux.sv */
`timescale 1ns/1ps

module xbar_req_mux
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  master_idx_t [N_BANK-1:0] win_idx_i,    // Winner of each bank
    input  row_t [N_MASTER-1:0]      row_i,        // Decoded row per master
    input  logic [N_MASTER-1:0]      data_wen_i,   // 1 load, 0 store
    input  data_t [N_MASTER-1:0]     data_wdata_i, // Store data per master
    input  be_t [N_MASTER-1:0]       data_be_i,    // Byte enables per master
    output row_t [N_BANK-1:0]        data_add_o,   // Row towards bank
    output logic [N_BANK-1:0]        data_wen_o,
    output data_t [N_BANK-1:0]       data_wdata_o,
    output be_t [N_BANK-1:0]         data_be_o,
    output master_id_t [N_BANK-1:0]  data_id_o     // One-hot tag of the winner
);

    //////////////////////////////
    // Per bank payload select

    // Fields follow the winner even when the bank is idle
    for (genvar b = 0; b < N_BANK; b++)
    begin : g_bank
        assign data_add_o[b]   = row_i[win_idx_i[b]];
        assign data_wen_o[b]   = data_wen_i[win_idx_i[b]];
        assign data_wdata_o[b] = data_wdata_i[win_idx_i[b]];
        assign data_be_o[b]    = data_be_i[win_idx_i[b]];

        // Binary index to one-hot tag, returned later with the response
        assign data_id_o[b]    = master_id_t'(1) << win_idx_i[b];
    end

endmodule

/* hw/xbar_arbiter.sv */
`timescale 1ns/1ps

module xbar_arbiter
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [N_BANK-1:0][N_MASTER-1:0] bank_req_i,  // Requesters per bank
    input  logic [N_BANK-1:0]               data_gnt_i,  // Bank ready to take
    output logic [N_BANK-1:0]               data_req_o,  // Request towards bank
    output master_idx_t [N_BANK-1:0]        win_idx_o,   // Winning master per bank
    output logic [N_MASTER-1:0]             data_gnt_o   // Grant back to masters
);

    master_idx_t [N_BANK-1:0] rr_ptr_q;  // Highest priority master of each bank
    master_idx_t [N_BANK-1:0] rr_ptr_d;
    logic [N_BANK-1:0]        bank_take; // Request handed over this cycle

    //////////////////////////////
    // Winner search

    always_comb
    begin : win_search
        int idx;
        for (int b = 0; b < N_BANK; b++)
        begin
            data_req_o[b] = |bank_req_i[b];  // Any requester wakes the bank
            win_idx_o[b]  = rr_ptr_q[b];     // Default when idle
            // Walk backwards so the nearest requester after the pointer wins
            for (int k = N_MASTER - 1; k >= 0; k--)
            begin
                idx = (int'(rr_ptr_q[b]) + k) % N_MASTER;
                if (bank_req_i[b][idx])
                    win_idx_o[b] = master_idx_t'(idx);
            end
            bank_take[b] = data_req_o[b] && data_gnt_i[b];
            // Rotate past the winner only when the bank actually took it
            if (bank_take[b])
                rr_ptr_d[b] = master_idx_t'((int'(win_idx_o[b]) + 1) % N_MASTER);
            else
                rr_ptr_d[b] = rr_ptr_q[b];
        end
    end

    //////////////////////////////
    // Master grants

    // A master sits in exactly one bank vector, so at most one term can fire
    always_comb
    begin
        for (int m = 0; m < N_MASTER; m++)
        begin
            data_gnt_o[m] = 1'b0;
            for (int b = 0; b < N_BANK; b++)
            begin
                if (bank_req_i[b][m] && data_gnt_i[b] &&
                    (win_idx_o[b] == master_idx_t'(m)))
                    data_gnt_o[m] = 1'b1;  // Winner of a ready bank
            end
        end
    end

    //////////////////////////////
    // Priority state

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            rr_ptr_q <= '0;        // Master 0 first after reset
        else
            rr_ptr_q <= rr_ptr_d;
    end

endmodule

/* hw/xbar_addr_decode.sv */
`timescale 1ns/1ps

module xbar_addr_decode
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic [N_MASTER-1:0]             data_req_i,  // Request per master
    input  addr_t [N_MASTER-1:0]            data_add_i,  // Byte address per master
    output bank_sel_t [N_MASTER-1:0]        bank_sel_o,  // Target bank per master
    output row_t [N_MASTER-1:0]             row_o,       // Row inside the target bank
    output logic [N_BANK-1:0][N_MASTER-1:0] bank_req_o   // Requesters seen by each bank
);

    //////////////////////////////
    // Address split

    always_comb
    begin
        for (int m = 0; m < N_MASTER; m++)
        begin
            bank_sel_o[m] = data_add_i[m][BANK_SEL_LSB +: BANK_SEL_W]; // Interleave bits
            row_o[m]      = data_add_i[m][ROW_LSB +: ROW_W];           // Word inside bank
        end
    end

    //////////////////////////////
    // Request matrix

    // One bit per master and bank, set only while that master requests
    for (genvar b = 0; b < N_BANK; b++)
    begin : g_bank
        for (genvar m = 0; m < N_MASTER; m++)
        begin : g_master
            assign bank_req_o[b][m] = data_req_i[m] &&
                                      (bank_sel_o[m] == bank_sel_t'(b));
        end
    end

endmodule

/* hw/xbar_types_pkg.sv */
package xbar_types_pkg;

    import xbar_cfg_pkg::*;

    //////////////////////////////
    // Payload types

    typedef logic [ADDR_W-1:0] addr_t;  // Master byte address
    typedef logic [DATA_W-1:0] data_t;  // Data word
    typedef logic [BE_W-1:0]   be_t;    // Byte enables

    //////////////////////////////
    // Routing types

    // Bank index taken from the address
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

    // Word address inside one bank
    typedef logic [ROW_W-1:0] row_t;

    typedef logic [N_MASTER-1:0]         master_id_t;  // One-hot master tag
    typedef logic [$clog2(N_MASTER)-1:0] master_idx_t; // Binary master number

endpackage

/* hw/xbar_cfg_pkg.sv */
package xbar_cfg_pkg;

    //////////////////////////////
    // Port counts

    localparam int unsigned N_MASTER = 4;  // Processor side masters
    localparam int unsigned N_BANK   = 4;  // Word interleaved banks, power of two

    //////////////////////////////
    // Bus widths

    localparam int unsigned ADDR_W = 32;        // Master byte address
    localparam int unsigned DATA_W = 32;        // One bank word
    localparam int unsigned BE_W   = DATA_W / 8; // One enable per byte

    //////////////////////////////
    // Address field layout

    // Byte offset inside a word
    localparam int unsigned BYTE_OFF_W = $clog2(BE_W);
    localparam int unsigned BANK_SEL_W = $clog2(N_BANK); // Bank index bits
    localparam int unsigned ROW_W      = 10;             // Words per bank as log2

    // Low word bits pick the bank
    localparam int unsigned BANK_SEL_LSB = BYTE_OFF_W;
    // Row sits right above the bank select
    localparam int unsigned ROW_LSB      = BYTE_OFF_W + BANK_SEL_W;

endpackage
